//--- filelist.f
rtl/ac97_pkg.sv
rtl/ac97_frame_if.sv
rtl/button_debounce.sv
rtl/volume_control.sv
rtl/ac97_command_sequencer.sv
rtl/ac97_frame_engine.sv
rtl/ac97_audio_top.sv
testbench/ac97_codec_model.sv
testbench/tb_ac97_audio.sv

//--- rtl/ac97_audio_top.sv
`timescale 1ns/1ps

module ac97_audio_top #(
  parameter int stable_cycles = ac97_pkg::debounce_cycles
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  input  logic ac97_bit_clock,
  input  logic ac97_sdata_in,
  input  logic [ac97_pkg::sample_width-1:0] playback_sample,
  output logic [ac97_pkg::sample_width-1:0] record_sample,
  output logic sample_valid,
  output logic [ac97_pkg::volume_width-1:0] volume,
  output logic audio_reset_b,
  output logic ac97_sdata_out,
  output logic ac97_synch
);

  logic [$clog2(ac97_pkg::codec_reset_cycles)-1:0] reset_count;
  logic codec_hold;
  logic [2:0] ready_sync;
  logic frame_start;
  logic [ac97_pkg::sample_width-1:0] playback_reg;

  ac97_frame_if i_frame_if ();

  ////////////////////////////////////////
  // codec reset delay
  ////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      reset_count <= '0;
      audio_reset_b <= 1'b0;
    end else if (reset_count == ac97_pkg::codec_reset_cycles - 1) begin
      audio_reset_b <= 1'b1;
    end else begin
      reset_count <= reset_count + 1'b1;
    end
  end

  // engine stays in reset with the codec
  assign codec_hold = ~audio_reset_b;

  ////////////////////////////////////////
  // frame_ready crossing
  ////////////////////////////////////////

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[1:0], i_frame_if.frame_ready};
    end
  end

  assign frame_start = ready_sync[1] & ~ready_sync[2];

  // sample_valid lines up with the new record_sample
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= frame_start;
    end
  end

  always_ff @(posedge clock_27mhz) begin
    if (frame_start) begin
      record_sample <= i_frame_if.pcm_in[ac97_pkg::pcm_width-1 -: ac97_pkg::sample_width];
    end
  end

  // playback held until the next pulse, low bits padded
  always_ff @(posedge clock_27mhz) begin
    if (sample_valid) begin
      playback_reg <= playback_sample;
    end
  end

  assign i_frame_if.pcm_out = {playback_reg,
                               {(ac97_pkg::pcm_width - ac97_pkg::sample_width){1'b0}}};

  ////////////////////////////////////////
  // submodules
  ////////////////////////////////////////

  volume_control #(.stable_cycles(stable_cycles)) i_volume_control (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .button_up   (button_up),
    .button_down (button_down),
    .volume      (volume)
  );

  ac97_command_sequencer i_command_sequencer (
    .clock_27mhz  (clock_27mhz),
    .reset        (reset),
    .sample_valid (sample_valid),
    .volume       (volume),
    .cmd          (i_frame_if.sequencer)
  );

  ac97_frame_engine i_frame_engine (
    .reset          (codec_hold),
    .frame          (i_frame_if.engine),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .ac97_synch     (ac97_synch),
    .ac97_bit_clock (ac97_bit_clock)
  );

endmodule

//--- rtl/ac97_command_sequencer.sv
`timescale 1ns/1ps

module ac97_command_sequencer (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic sample_valid,
  input  logic [ac97_pkg::volume_width-1:0] volume,
  ac97_frame_if.sequencer cmd
);

  logic [ac97_pkg::seq_state_width-1:0] state;
  logic [ac97_pkg::volume_width-1:0] attenuation;
  logic [ac97_pkg::cmd_addr_width-1:0] next_address;
  logic [ac97_pkg::cmd_data_width-1:0] next_data;

  // codec wants attenuation, not gain
  assign attenuation = ac97_pkg::volume_max[ac97_pkg::volume_width-1:0] - volume;

  ////////////////////////////////////////
  // register table
  ////////////////////////////////////////

  always_comb begin
    next_address = ac97_pkg::reg_read_id;
    next_data = '0;
    case (state)
      4'd3: begin
        next_address = ac97_pkg::reg_headphone_vol;
        next_data = {3'b000, attenuation, 3'b000, attenuation};
      end
      4'd5: begin
        next_address = ac97_pkg::reg_pcm_vol;
        next_data = ac97_pkg::pcm_vol_value;
      end
      4'd6: begin
        // same source on both channels
        next_address = ac97_pkg::reg_record_select;
        next_data = {5'b00000, ac97_pkg::record_source_mic,
                     5'b00000, ac97_pkg::record_source_mic};
      end
      4'd7: begin
        next_address = ac97_pkg::reg_record_gain;
        next_data = ac97_pkg::record_gain_value;
      end
      4'd9: begin
        next_address = ac97_pkg::reg_mic_vol;
        next_data = ac97_pkg::mic_gain_value;
      end
      4'd10: begin
        next_address = ac97_pkg::reg_beep_vol;
        next_data = ac97_pkg::beep_value;
      end
      4'd11: begin
        next_address = ac97_pkg::reg_general;
        next_data = ac97_pkg::general_value;
      end
      // the rest just read the ID register
      default: begin
        next_address = ac97_pkg::reg_read_id;
        next_data = '0;
      end
    endcase
  end

  // one step per frame, state wraps on its own
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state <= '0;
      cmd.cmd_valid <= 1'b0;
    end else if (sample_valid) begin
      state <= state + 1'b1;
      if (state == '0) begin
        cmd.cmd_valid <= 1'b1;
      end
    end
  end

  // held between pulses so the engine can latch it in its own domain
  always_ff @(posedge clock_27mhz) begin
    if (sample_valid) begin
      cmd.cmd_address <= next_address;
      cmd.cmd_data <= next_data;
    end
  end

endmodule

//--- rtl/ac97_frame_engine.sv
`timescale 1ns/1ps

module ac97_frame_engine (
  input  logic reset,
  ac97_frame_if.engine frame,
  output logic ac97_sdata_out,
  input  logic ac97_sdata_in,
  output logic ac97_synch,
  input  logic ac97_bit_clock
);

  logic reset_meta;
  logic bit_reset;
  logic [ac97_pkg::bit_count_width-1:0] bit_count;
  logic [ac97_pkg::cmd_addr_width-1:0] l_cmd_address;
  logic [ac97_pkg::cmd_data_width-1:0] l_cmd_data;
  logic l_cmd_valid;
  logic [ac97_pkg::pcm_width-1:0] l_pcm;
  logic l_pcm_valid;
  logic [ac97_pkg::slot_bits-1:0] tx_shift;
  logic [ac97_pkg::slot_bits-1:0] slot_word;
  logic slot_load;
  logic in_slots;

  // reset comes from the 27 MHz side
  always_ff @(posedge ac97_bit_clock) begin
    reset_meta <= reset;
    bit_reset <= reset_meta;
  end

  ////////////////////////////////////////
  // frame counter, sync, frame_ready
  ////////////////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (bit_reset) begin
      bit_count <= '0;
      ac97_synch <= 1'b0;
      frame.frame_ready <= 1'b0;
    end else begin
      bit_count <= bit_count + 1'b1;
      if (bit_count == ac97_pkg::frame_bits - 1) begin
        ac97_synch <= 1'b1;
      end else if (bit_count == ac97_pkg::sync_high_bits - 1) begin
        ac97_synch <= 1'b0;
      end
      if (bit_count == ac97_pkg::frame_ready_set_bit) begin
        frame.frame_ready <= 1'b1;
      end else if (bit_count == ac97_pkg::frame_ready_clear_bit) begin
        frame.frame_ready <= 1'b0;
      end
    end
  end

  // take the user side at the last bit, so the first frame is empty
  always_ff @(posedge ac97_bit_clock) begin
    if (bit_reset) begin
      l_cmd_valid <= 1'b0;
      l_pcm_valid <= 1'b0;
    end else if (bit_count == ac97_pkg::frame_bits - 1) begin
      l_cmd_valid <= frame.cmd_valid;
      l_pcm_valid <= 1'b1;
    end
  end

  always_ff @(posedge ac97_bit_clock) begin
    if (bit_count == ac97_pkg::frame_bits - 1) begin
      l_cmd_address <= frame.cmd_address;
      l_cmd_data <= frame.cmd_data;
      l_pcm <= frame.pcm_out;
    end
  end

  ////////////////////////////////////////
  // serializer
  ////////////////////////////////////////

  // next slot word, loaded on the last bit of the slot before
  always_comb begin
    slot_load = 1'b1;
    slot_word = '0;
    case (bit_count)
      ac97_pkg::slot1_start - 1: begin
        if (l_cmd_valid) begin
          slot_word = {l_cmd_address,
                       {(ac97_pkg::slot_bits - ac97_pkg::cmd_addr_width){1'b0}}};
        end
      end
      ac97_pkg::slot2_start - 1: begin
        if (l_cmd_valid) begin
          slot_word = {l_cmd_data,
                       {(ac97_pkg::slot_bits - ac97_pkg::cmd_data_width){1'b0}}};
        end
      end
      // mono, same sample left and right
      ac97_pkg::slot3_start - 1,
      ac97_pkg::slot4_start - 1: begin
        if (l_pcm_valid) begin
          slot_word = l_pcm;
        end
      end
      default: slot_load = 1'b0;
    endcase
  end

  assign in_slots = (bit_count >= ac97_pkg::slot1_start) &&
                    (bit_count < ac97_pkg::slot4_start + ac97_pkg::slot_bits);

  always_ff @(posedge ac97_bit_clock) begin
    if (slot_load) begin
      tx_shift <= slot_word;
    end else begin
      tx_shift <= {tx_shift[ac97_pkg::slot_bits-2:0], 1'b0};
    end
  end

  always_ff @(posedge ac97_bit_clock) begin
    if (bit_reset) begin
      ac97_sdata_out <= 1'b0;
    end else if (bit_count <= ac97_pkg::tag_slot_end) begin
      // slot 0 tags
      case (bit_count[3:0])
        4'd0: ac97_sdata_out <= 1'b1;
        4'd1, 4'd2: ac97_sdata_out <= l_cmd_valid;
        4'd3, 4'd4: ac97_sdata_out <= l_pcm_valid;
        default: ac97_sdata_out <= 1'b0;
      endcase
    end else if (in_slots) begin
      ac97_sdata_out <= tx_shift[ac97_pkg::slot_bits-1];
    end else begin
      ac97_sdata_out <= 1'b0;
    end
  end

  // codec data is stable on the falling edge, slot 3 lands one bit late
  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count > ac97_pkg::slot3_start &&
        bit_count <= ac97_pkg::slot3_start + ac97_pkg::slot_bits) begin
      frame.pcm_in <= {frame.pcm_in[ac97_pkg::pcm_width-2:0], ac97_sdata_in};
    end
  end

endmodule

//--- rtl/ac97_frame_if.sv
`timescale 1ns/1ps

interface ac97_frame_if;

  // command word for the next frame
  logic [ac97_pkg::cmd_addr_width-1:0] cmd_address;
  logic [ac97_pkg::cmd_data_width-1:0] cmd_data;
  logic cmd_valid;

  // pcm samples, codec width
  logic [ac97_pkg::pcm_width-1:0] pcm_out;
  logic [ac97_pkg::pcm_width-1:0] pcm_in;

  // bit clock domain, high in the second half of the frame
  logic frame_ready;

  modport sequencer (output cmd_address, output cmd_data, output cmd_valid);

  modport host (output pcm_out, input pcm_in, input frame_ready);

  modport engine (
    input  cmd_address,
    input  cmd_data,
    input  cmd_valid,
    input  pcm_out,
    output pcm_in,
    output frame_ready
  );

endinterface

//--- rtl/ac97_pkg.sv
package ac97_pkg;

  ////////////////////////////////////////
  // frame layout, counted in bit clocks
  ////////////////////////////////////////

  localparam int frame_bits = 256;
  localparam int bit_count_width = 8;
  localparam int sync_high_bits = 16;
  localparam int tag_slot_end = 15;
  localparam int slot_bits = 20;

  // first bit of each slot
  localparam int slot1_start = 16;
  localparam int slot2_start = 36;
  localparam int slot3_start = 56;
  localparam int slot4_start = 76;

  // frame_ready window, wraps through the end of the frame
  localparam int frame_ready_set_bit = 128;
  localparam int frame_ready_clear_bit = 2;

  ////////////////////////////////////////
  // data widths
  ////////////////////////////////////////

  localparam int pcm_width = 20;
  localparam int sample_width = 18;
  localparam int cmd_addr_width = 8;
  localparam int cmd_data_width = 16;
  localparam int volume_width = 5;
  localparam int volume_max = 31;
  localparam int volume_reset = 8;
  localparam int seq_state_width = 4;

  // timing in clock_27mhz cycles
  localparam int codec_reset_cycles = 1024;
  localparam int debounce_cycles = 270000;

  ////////////////////////////////////////
  // codec register table
  ////////////////////////////////////////

  localparam logic [cmd_addr_width-1:0] reg_read_id = 8'h80;
  localparam logic [cmd_addr_width-1:0] reg_headphone_vol = 8'h04;
  localparam logic [cmd_addr_width-1:0] reg_pcm_vol = 8'h18;
  localparam logic [cmd_addr_width-1:0] reg_record_select = 8'h1A;
  localparam logic [cmd_addr_width-1:0] reg_record_gain = 8'h1C;
  localparam logic [cmd_addr_width-1:0] reg_mic_vol = 8'h0E;
  localparam logic [cmd_addr_width-1:0] reg_beep_vol = 8'h0A;
  localparam logic [cmd_addr_width-1:0] reg_general = 8'h20;

  // fixed data words
  localparam logic [cmd_data_width-1:0] pcm_vol_value = 16'h0808;
  // record gain at max
  localparam logic [cmd_data_width-1:0] record_gain_value = 16'h0F0F;
  // +20 dB mic boost
  localparam logic [cmd_data_width-1:0] mic_gain_value = 16'h8048;
  localparam logic [cmd_data_width-1:0] beep_value = 16'h0000;
  // pcm out bypasses mix1
  localparam logic [cmd_data_width-1:0] general_value = 16'h8000;

  // record source select code for the mic input
  localparam logic [2:0] record_source_mic = 3'd0;

endpackage

//--- rtl/button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
  parameter int stable_cycles = ac97_pkg::debounce_cycles
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  logic [$clog2(stable_cycles + 1)-1:0] count;
  logic last_sample;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      last_sample <= noisy;
      clean <= noisy;
    end else if (noisy != last_sample) begin
      // input moved, start the stability window over
      last_sample <= noisy;
      count <= '0;
    end else if (count == stable_cycles) begin
      // held long enough
      clean <= last_sample;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

//--- rtl/volume_control.sv
`timescale 1ns/1ps

module volume_control #(
  parameter int stable_cycles = ac97_pkg::debounce_cycles
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  output logic [ac97_pkg::volume_width-1:0] volume
);

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_press;
  logic down_press;

  // buttons are active low
  button_debounce #(.stable_cycles(stable_cycles)) i_up_debounce (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_up),
    .clean       (up_clean)
  );

  button_debounce #(.stable_cycles(stable_cycles)) i_down_debounce (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .noisy       (~button_down),
    .clean       (down_clean)
  );

  assign up_press = up_clean & ~up_prev;
  assign down_press = down_clean & ~down_prev;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      up_prev <= 1'b0;
      down_prev <= 1'b0;
      volume <= ac97_pkg::volume_reset[ac97_pkg::volume_width-1:0];
    end else begin
      up_prev <= up_clean;
      down_prev <= down_clean;
      // saturate at both ends
      if (up_press && volume != ac97_pkg::volume_max) begin
        volume <= volume + 1'b1;
      end else if (down_press && volume != '0) begin
        volume <= volume - 1'b1;
      end
    end
  end

endmodule

//--- testbench/ac97_codec_model.sv
`timescale 1ns/1ps

module ac97_codec_model #(
  parameter logic [31:0] seed_init = 32'hcab
) (
  input  logic ac97_bit_clock,
  input  logic ac97_synch,
  input  logic ac97_sdata_out,
  output logic ac97_sdata_in,
  output logic [ac97_pkg::pcm_width-1:0] slot3_word,
  output logic [15:0] tags,
  output logic [ac97_pkg::slot_bits-1:0] slot1,
  output logic [ac97_pkg::slot_bits-1:0] slot2,
  output logic [ac97_pkg::slot_bits-1:0] slot3,
  output logic [ac97_pkg::slot_bits-1:0] slot4,
  output int frame_count,
  output int synch_length
);

  logic [ac97_pkg::frame_bits-1:0] rx_frame;
  logic synch_last;
  logic started;
  int bit_pos;
  integer seed;

  initial begin
    seed = seed_init;
    ac97_sdata_in = 1'b0;
    slot3_word = '0;
    rx_frame = '0;
    synch_last = 1'b0;
    started = 1'b0;
    bit_pos = 0;
    frame_count = 0;
    synch_length = 0;
  end

  ////////////////////////////////////////
  // receive side, sampled on falling edges
  ////////////////////////////////////////

  // frame bit k ends up at rx_frame[255-k] when the next sync arrives
  always @(negedge ac97_bit_clock) begin
    rx_frame = {rx_frame[ac97_pkg::frame_bits-2:0], ac97_sdata_out};
    bit_pos = bit_pos + 1;
    // high time of the sync pulse, in bits from its rising edge
    if (started && ac97_synch === 1'b0 && synch_last === 1'b1) begin
      synch_length = bit_pos;
    end
    if (ac97_synch === 1'b1 && synch_last === 1'b0) begin
      if (started) begin
        tags = rx_frame[255 -: 16];
        slot1 = rx_frame[255 - ac97_pkg::slot1_start -: ac97_pkg::slot_bits];
        slot2 = rx_frame[255 - ac97_pkg::slot2_start -: ac97_pkg::slot_bits];
        slot3 = rx_frame[255 - ac97_pkg::slot3_start -: ac97_pkg::slot_bits];
        slot4 = rx_frame[255 - ac97_pkg::slot4_start -: ac97_pkg::slot_bits];
        frame_count = frame_count + 1;
      end
      // new recorded word for the frame that starts now
      started = 1'b1;
      bit_pos = 0;
      slot3_word = $random(seed);
    end
    synch_last = ac97_synch;
  end

  ////////////////////////////////////////
  // transmit side, slot 3 only
  ////////////////////////////////////////

  // msb first, changes on the rising edge so the controller sees it settled
  always @(posedge ac97_bit_clock) begin
    if (started && bit_pos >= ac97_pkg::slot3_start &&
        bit_pos < ac97_pkg::slot3_start + ac97_pkg::slot_bits) begin
      ac97_sdata_in <= slot3_word[ac97_pkg::slot3_start + ac97_pkg::slot_bits - 1 - bit_pos];
    end else begin
      ac97_sdata_in <= 1'b0;
    end
  end

endmodule

//--- testbench/tb_ac97_audio.sv
`timescale 1ns/1ps

module tb_ac97_audio;

  localparam int stable_cycles = 32;
  localparam int press_cycles = 100;
  localparam int glitch_cycles = 10;
  localparam int gap_cycles = 60;
  localparam int min_frames = 40;
  localparam longint bit_period_ns = 20;
  localparam longint timeout_ns = 400 * ac97_pkg::frame_bits * bit_period_ns + 50000;

  logic clock_27mhz = 1'b0;
  logic ac97_bit_clock = 1'b0;
  logic reset = 1'b1;
  logic button_up = 1'b1;
  logic button_down = 1'b1;
  logic [ac97_pkg::sample_width-1:0] playback_sample = '0;
  logic [ac97_pkg::sample_width-1:0] record_sample;
  logic sample_valid;
  logic [ac97_pkg::volume_width-1:0] volume;
  logic audio_reset_b;
  logic ac97_sdata_out;
  logic ac97_sdata_in;
  logic ac97_synch;

  // decoded frames from the codec model
  logic [ac97_pkg::pcm_width-1:0] model_slot3_word;
  logic [15:0] model_tags;
  logic [19:0] model_slot1;
  logic [19:0] model_slot2;
  logic [19:0] model_slot3;
  logic [19:0] model_slot4;
  int model_synch_length;
  int frames_seen;
  int frames_checked = 0;

  // reference model state
  integer seed = 32'hcab;
  logic [ac97_pkg::volume_width-1:0] ref_volume = ac97_pkg::volume_reset;
  logic [3:0] ref_state = '0;
  logic ref_cmd_valid = 1'b0;
  logic last_valid = 1'b0;
  logic codec_released = 1'b0;
  int codec_reset_count;
  logic [15:0] exp_tag_q[$];
  logic [19:0] exp_slot1_q[$];
  logic [19:0] exp_slot2_q[$];
  logic [19:0] exp_pcm_q[$];

  always #2 clock_27mhz = ~clock_27mhz;
  always #10 ac97_bit_clock = ~ac97_bit_clock;

  ac97_audio_top #(.stable_cycles(stable_cycles)) i_ac97_audio_top (
    .clock_27mhz     (clock_27mhz),
    .reset           (reset),
    .button_up       (button_up),
    .button_down     (button_down),
    .ac97_bit_clock  (ac97_bit_clock),
    .ac97_sdata_in   (ac97_sdata_in),
    .playback_sample (playback_sample),
    .record_sample   (record_sample),
    .sample_valid    (sample_valid),
    .volume          (volume),
    .audio_reset_b   (audio_reset_b),
    .ac97_sdata_out  (ac97_sdata_out),
    .ac97_synch      (ac97_synch)
  );

  ac97_codec_model #(.seed_init(32'hcab)) i_codec_model (
    .ac97_bit_clock (ac97_bit_clock),
    .ac97_synch     (ac97_synch),
    .ac97_sdata_out (ac97_sdata_out),
    .ac97_sdata_in  (ac97_sdata_in),
    .slot3_word     (model_slot3_word),
    .tags           (model_tags),
    .slot1          (model_slot1),
    .slot2          (model_slot2),
    .slot3          (model_slot3),
    .slot4          (model_slot4),
    .frame_count    (frames_seen),
    .synch_length   (model_synch_length)
  );

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // address and data of the register write for one sequencer step
  function automatic logic [23:0] command_for_state(input logic [3:0] state,
                                                    input logic [4:0] vol);
    logic [4:0] att;
    att = 5'd31 - vol;
    case (state)
      4'd3: return {ac97_pkg::reg_headphone_vol, 3'b000, att, 3'b000, att};
      4'd5: return {ac97_pkg::reg_pcm_vol, ac97_pkg::pcm_vol_value};
      4'd6: return {ac97_pkg::reg_record_select, 5'b00000, ac97_pkg::record_source_mic,
                    5'b00000, ac97_pkg::record_source_mic};
      4'd7: return {ac97_pkg::reg_record_gain, ac97_pkg::record_gain_value};
      4'd9: return {ac97_pkg::reg_mic_vol, ac97_pkg::mic_gain_value};
      4'd10: return {ac97_pkg::reg_beep_vol, ac97_pkg::beep_value};
      4'd11: return {ac97_pkg::reg_general, ac97_pkg::general_value};
      default: return {ac97_pkg::reg_read_id, 16'h0000};
    endcase
  endfunction

  // called on a rising edge, volume moves stable_cycles + 3 edges later
  task automatic press_button(input logic up, input int hold);
    int i;
    if (up) button_up <= 1'b0;
    else button_down <= 1'b0;
    for (i = 1; i <= hold; i++) begin
      @(posedge clock_27mhz);
      if (i == stable_cycles + 3) begin
        if (up && ref_volume != 5'd31) ref_volume <= ref_volume + 1'b1;
        else if (!up && ref_volume != 5'd0) ref_volume <= ref_volume - 1'b1;
      end
    end
    button_up <= 1'b1;
    button_down <= 1'b1;
    repeat (gap_cycles) @(posedge clock_27mhz);
  endtask

  ////////////////////////////////////////
  // 27 MHz side checks and playback
  ////////////////////////////////////////

  always @(posedge clock_27mhz) begin : sample_monitor
    logic [23:0] command;
    if (!reset) begin
      check_equal(volume, ref_volume, "volume");
      if (codec_released) check_equal(audio_reset_b, 1'b1, "audio_reset_b after release");
      if (sample_valid === 1'b1) begin
        check_equal(last_valid, 1'b0, "sample_valid width");
        check_equal(record_sample, model_slot3_word[19:2], "record_sample");
        if (ref_state == 4'd0) ref_cmd_valid = 1'b1;
        command = command_for_state(ref_state, ref_volume);
        exp_tag_q.push_back({1'b1, ref_cmd_valid, ref_cmd_valid, 2'b11, 11'b0});
        exp_slot1_q.push_back(ref_cmd_valid ? {command[23:16], 12'h000} : 20'h0);
        exp_slot2_q.push_back(ref_cmd_valid ? {command[15:0], 4'h0} : 20'h0);
        exp_pcm_q.push_back({playback_sample, 2'b00});
        ref_state = ref_state + 1'b1;
        playback_sample <= $random(seed);
      end
      last_valid <= (sample_valid === 1'b1);
    end
  end

  // decoded frame is stable half a bit clock after the model updates it
  always @(posedge ac97_bit_clock) begin
    if (frames_seen != frames_checked) begin
      check_equal(exp_tag_q.size(), 2, "sample_valid pulses per frame");
      check_equal(model_synch_length, ac97_pkg::sync_high_bits, "ac97_synch high bits");
      check_equal(model_tags, exp_tag_q.pop_front(), "slot 0 tags");
      check_equal(model_slot1, exp_slot1_q.pop_front(), "slot 1 command address");
      check_equal(model_slot2, exp_slot2_q.pop_front(), "slot 2 command data");
      check_equal(model_slot3, exp_pcm_q[0], "slot 3 left pcm");
      check_equal(model_slot4, exp_pcm_q.pop_front(), "slot 4 right pcm");
      frames_checked = frames_checked + 1;
    end
  end

  initial begin
    playback_sample = $random(seed);
    repeat (2) @(posedge clock_27mhz);
    reset <= 1'b0;
    @(posedge clock_27mhz);
    check_equal(sample_valid, 1'b0, "sample_valid after reset");
    codec_reset_count = 0;
    while (audio_reset_b !== 1'b1 && codec_reset_count < 2 * ac97_pkg::codec_reset_cycles) begin
      codec_reset_count++;
      @(posedge clock_27mhz);
    end
    check_equal(codec_reset_count, ac97_pkg::codec_reset_cycles, "codec reset length");
    codec_released = 1'b1;

    // single steps, then short glitches
    repeat (3) press_button(1'b1, press_cycles);
    repeat (2) press_button(1'b0, press_cycles);
    check_equal(volume, 5'd9, "volume after single steps");
    press_button(1'b1, glitch_cycles);
    press_button(1'b0, glitch_cycles);
    check_equal(volume, 5'd9, "volume after glitches");

    // saturation at both ends
    repeat (30) press_button(1'b1, press_cycles);
    check_equal(volume, ac97_pkg::volume_max, "volume at top");
    repeat (40) press_button(1'b0, press_cycles);
    check_equal(volume, 5'd0, "volume at bottom");
    repeat (5) press_button(1'b1, press_cycles);
    check_equal(volume, 5'd5, "volume after final steps");

    wait (frames_checked >= min_frames);
    @(posedge clock_27mhz);
    $display("Regression passed");
    $finish;
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule
